// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= f8_tb
OBJ_DIR ?= obj_dir
FILELIST ?= src.f
VFLAGS ?= --binary -Wno-fatal

SRCS := $(filter %.sv,$(shell cat $(FILELIST)))
HDRS := $(wildcard *.svh)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(OBJ_DIR)

// ==== f8_addsub.sv ====
`timescale 1ns/1ns

module f8_addsub
#(
	parameter type data_t = logic [7:0]
)
(
	input data_t a,
	input data_t b,
	input logic cin,
	output data_t sum,
	output logic cout,
	output logic ovf,
	output logic half
);
	localparam int W = $bits(data_t);

	logic [W:0] full;
	logic [4:0] nibble;

	assign full = {1'b0, a} + {1'b0, b} + {{W{1'b0}}, cin};
	assign sum = full[W-1:0];
	assign cout = full[W];
	// operands agree in sign but the sum does not
	assign ovf = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
	assign nibble = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0000, cin};
	assign half = nibble[4];
endmodule

// ==== f8_alu16.sv ====
`timescale 1ns/1ns

module f8_alu16
(
	input f8_pkg::inst_t inst,
	input f8_pkg::regs_t regs,
	output f8_pkg::alu16_res_t res
);
	f8_pkg::word_t imm;
	f8_pkg::word_t op;
	f8_pkg::word_t sum;
	logic cin;
	logic cout;
	logic ovf;

	assign imm = {inst.b2, inst.b1};

	always_comb
	begin
		op = imm;
		cin = 1'b0;
		case (inst.opcode)
			f8_pkg::OP_SUBW_Y_IMMD:
			begin
				op = ~imm;
				cin = 1'b1;
			end
			f8_pkg::OP_INCW_Y:
				op = 16'h0001;
			default:
			begin
			end
		endcase
	end

	f8_addsub #(.data_t(f8_pkg::word_t)) add_i
	(
		.a(regs.y),
		.b(op),
		.cin(cin),
		.sum(sum),
		.cout(cout),
		.ovf(ovf),
		.half()
	);

	// word ops leave h alone
	assign res.result = sum;
	assign res.f = '{o: ovf, z: (sum == 16'h0000), n: sum[15], c: cout, h: regs.f.h};
endmodule

// ==== f8_alu8.sv ====
`timescale 1ns/1ns

module f8_alu8
(
	input f8_pkg::inst_t inst,
	input f8_pkg::regs_t regs,
	output f8_pkg::alu8_res_t res
);
	f8_pkg::byte_t op;
	f8_pkg::byte_t sum;
	logic cin;
	logic cout;
	logic ovf;
	logic half;

	// subtract as add of the inverted operand
	always_comb
	begin
		op = inst.b1;
		cin = 1'b0;
		case (inst.opcode)
			f8_pkg::OP_ADC_XL_IMMD:
				cin = regs.f.c;
			f8_pkg::OP_SUB_XL_IMMD:
			begin
				op = ~inst.b1;
				cin = 1'b1;
			end
			f8_pkg::OP_SBC_XL_IMMD:
			begin
				op = ~inst.b1;
				cin = regs.f.c;
			end
			f8_pkg::OP_INC_XL:
				op = 8'h01;
			f8_pkg::OP_DEC_XL:
			begin
				op = 8'hfe;
				cin = 1'b1;
			end
			default:
			begin
			end
		endcase
	end

	f8_addsub #(.data_t(f8_pkg::byte_t)) add_i
	(
		.a(regs.x[7:0]),
		.b(op),
		.cin(cin),
		.sum(sum),
		.cout(cout),
		.ovf(ovf),
		.half(half)
	);

	always_comb
	begin
		res.f = regs.f;
		case (inst.opcode)
			f8_pkg::OP_AND_XL_IMMD:
				res.result = regs.x[7:0] & inst.b1;
			f8_pkg::OP_OR_XL_IMMD:
				res.result = regs.x[7:0] | inst.b1;
			f8_pkg::OP_XOR_XL_IMMD:
				res.result = regs.x[7:0] ^ inst.b1;
			default:
			begin
				res.result = sum;
				res.f.o = ovf;
				res.f.c = cout;
				res.f.h = half;
			end
		endcase
		res.f.z = (res.result == 8'h00);
		res.f.n = res.result[7];
	end
endmodule

// ==== f8_cfg.svh ====
`ifndef F8_CFG_SVH
`define F8_CFG_SVH

// pc loaded by reset
`define F8_RESET_PC 16'h4000

// byte address width
`define F8_ADDR_W 16

// word index width of one byte bank
`define F8_BANK_W 15

`endif

// ==== f8_cpu.sv ====
`timescale 1ns/1ns

module f8_cpu
(
	input logic clk,
	input logic reset,
	input f8_pkg::byte_t rd_data_even,
	input f8_pkg::byte_t rd_data_odd,
	output f8_pkg::bank_addr_t rd_addr_even,
	output f8_pkg::bank_addr_t rd_addr_odd,
	output f8_pkg::bank_wr_t wr_even,
	output f8_pkg::bank_wr_t wr_odd,
	output logic trap
);
	f8_pkg::inst_t inst;
	logic exec;
	f8_pkg::word_t memop;
	f8_pkg::regs_t regs;
	f8_pkg::alu8_res_t alu8_res;
	f8_pkg::alu16_res_t alu16_res;

	f8_fetch fetch_i
	(
		.clk(clk),
		.reset(reset),
		.regs(regs),
		.rd_data_even(rd_data_even),
		.rd_data_odd(rd_data_odd),
		.rd_addr_even(rd_addr_even),
		.rd_addr_odd(rd_addr_odd),
		.inst(inst),
		.exec(exec),
		.memop(memop),
		.trap(trap)
	);

	// both ALUs see every instruction, execute picks the result
	f8_alu8 alu8_i
	(
		.inst(inst),
		.regs(regs),
		.res(alu8_res)
	);

	f8_alu16 alu16_i
	(
		.inst(inst),
		.regs(regs),
		.res(alu16_res)
	);

	f8_execute execute_i
	(
		.clk(clk),
		.reset(reset),
		.inst(inst),
		.exec(exec),
		.memop(memop),
		.alu8(alu8_res),
		.alu16(alu16_res),
		.regs(regs),
		.wr_even(wr_even),
		.wr_odd(wr_odd)
	);
endmodule

// ==== f8_execute.sv ====
`timescale 1ns/1ns

`include "f8_cfg.svh"

module f8_execute
(
	input logic clk,
	input logic reset,
	input f8_pkg::inst_t inst,
	input logic exec,
	input f8_pkg::word_t memop,
	input f8_pkg::alu8_res_t alu8,
	input f8_pkg::alu16_res_t alu16,
	output f8_pkg::regs_t regs,
	output f8_pkg::bank_wr_t wr_even,
	output f8_pkg::bank_wr_t wr_odd
);
	f8_pkg::word_t imm16;
	f8_pkg::word_t x_data;
	logic [1:0] x_we;
	f8_pkg::word_t y_data;
	logic [1:0] y_we;
	f8_pkg::word_t next_sp;
	f8_pkg::flags_t next_f;
	logic [`F8_ADDR_W-1:0] wr_addr;
	f8_pkg::bank_addr_t wr_index;
	f8_pkg::word_t wr_data;
	logic [1:0] wr_en;

	assign imm16 = {inst.b2, inst.b1};

	always_comb
	begin
		x_data = {alu8.result, alu8.result};
		x_we = 2'b00;
		y_data = alu16.result;
		y_we = 2'b00;
		next_sp = regs.sp;
		next_f = regs.f;
		wr_addr = imm16;
		wr_data = regs.y;
		wr_en = 2'b00;
		case (inst.opcode)
			f8_pkg::OP_LD_XL_IMMD:
			begin
				x_data = {inst.b1, inst.b1};
				x_we = 2'b01;
			end
			f8_pkg::OP_ADD_XL_IMMD, f8_pkg::OP_SUB_XL_IMMD, f8_pkg::OP_ADC_XL_IMMD,
			f8_pkg::OP_SBC_XL_IMMD, f8_pkg::OP_AND_XL_IMMD, f8_pkg::OP_OR_XL_IMMD,
			f8_pkg::OP_XOR_XL_IMMD, f8_pkg::OP_INC_XL, f8_pkg::OP_DEC_XL:
			begin
				x_we = 2'b01;
				next_f = alu8.f;
			end
			f8_pkg::OP_LDW_Y_IMMD:
			begin
				y_data = imm16;
				y_we = 2'b11;
				next_f.z = (imm16 == 16'h0000);
				next_f.n = imm16[15];
			end
			f8_pkg::OP_ADDW_Y_IMMD, f8_pkg::OP_SUBW_Y_IMMD, f8_pkg::OP_INCW_Y:
			begin
				y_we = 2'b11;
				next_f = alu16.f;
			end
			f8_pkg::OP_LD_DIR_XL:
			begin
				wr_data = {8'h00, regs.x[7:0]};
				wr_en = 2'b01;
			end
			f8_pkg::OP_LDW_DIR_Y:
				wr_en = 2'b11;
			f8_pkg::OP_LDW_SP_Y:
				next_sp = regs.y;
			f8_pkg::OP_PUSHW_Y:
			begin
				wr_addr = regs.sp - 16'd2;
				wr_en = 2'b11;
				next_sp = regs.sp - 16'd2;
			end
			f8_pkg::OP_POPW_Y:
			begin
				y_data = memop;
				y_we = 2'b11;
				next_sp = regs.sp + 16'd2;
			end
			default:
			begin
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (exec && x_we[0])
			regs.x[7:0] <= x_data[7:0];
		if (exec && x_we[1])
			regs.x[15:8] <= x_data[15:8];
		if (exec && y_we[0])
			regs.y[7:0] <= y_data[7:0];
		if (exec && y_we[1])
			regs.y[15:8] <= y_data[15:8];
		if (reset)
		begin
			regs.sp <= 16'h0000;
			regs.f <= '0;
		end
		else if (exec)
		begin
			regs.sp <= next_sp;
			regs.f <= next_f;
		end
	end

	// low byte goes to the bank of the address, high byte to the other one
	assign wr_index = wr_addr[`F8_ADDR_W-1:1];

	always_comb
	begin
		wr_odd.addr = wr_index;
		wr_even.addr = wr_addr[0] ? wr_index + 1'b1 : wr_index;
		if (wr_addr[0])
		begin
			wr_odd.data = wr_data[7:0];
			wr_odd.en = exec && wr_en[0];
			wr_even.data = wr_data[15:8];
			wr_even.en = exec && wr_en[1];
		end
		else
		begin
			wr_even.data = wr_data[7:0];
			wr_even.en = exec && wr_en[0];
			wr_odd.data = wr_data[15:8];
			wr_odd.en = exec && wr_en[1];
		end
	end
endmodule

// ==== f8_fetch.sv ====
`timescale 1ns/1ns

`include "f8_cfg.svh"

module f8_fetch
(
	input logic clk,
	input logic reset,
	input f8_pkg::regs_t regs,
	input f8_pkg::byte_t rd_data_even,
	input f8_pkg::byte_t rd_data_odd,
	output f8_pkg::bank_addr_t rd_addr_even,
	output f8_pkg::bank_addr_t rd_addr_odd,
	output f8_pkg::inst_t inst,
	output logic exec,
	output f8_pkg::word_t memop,
	output logic trap
);
	f8_pkg::word_t pc;
	f8_pkg::word_t next_pc;
	f8_pkg::inst_t inst_q;
	logic upper;
	logic operand;
	logic first;
	logic more;
	logic taken;
	f8_pkg::byte_t lo_byte;
	f8_pkg::byte_t hi_byte;
	logic [`F8_ADDR_W-1:0] rd_addr;
	f8_pkg::bank_addr_t rd_index;

	// byte at pc (pc+2 in the upper phase) and the byte after it
	assign lo_byte = pc[0] ? rd_data_odd : rd_data_even;
	assign hi_byte = pc[0] ? rd_data_even : rd_data_odd;
	assign first = !upper && !operand;

	always_comb
	begin
		if (upper)
			inst = '{opcode: inst_q.opcode, b1: inst_q.b1, b2: lo_byte};
		else if (operand)
			inst = inst_q;
		else
			inst = '{opcode: f8_pkg::opcode_t'(lo_byte), b1: hi_byte, b2: 8'h00};
	end

	// popped word, low byte at sp
	assign memop = regs.sp[0] ? {rd_data_even, rd_data_odd} : {rd_data_odd, rd_data_even};

	assign more = first && (f8_pkg::is_three_byte(inst.opcode) || inst.opcode == f8_pkg::OP_POPW_Y);
	assign trap = !reset && first && inst.opcode == f8_pkg::OP_TRAP;
	assign exec = !reset && !trap && !more;

	always_comb
	begin
		case (inst.opcode)
			f8_pkg::OP_JR_D:
				taken = 1'b1;
			f8_pkg::OP_JRZ_D:
				taken = regs.f.z;
			f8_pkg::OP_JRNZ_D:
				taken = !regs.f.z;
			f8_pkg::OP_JRC_D:
				taken = regs.f.c;
			default:
				taken = 1'b0;
		endcase
	end

	always_comb
	begin
		if (reset)
			next_pc = `F8_RESET_PC;
		else if (!exec)
			next_pc = pc;
		else if (taken)
			next_pc = pc + {{8{inst.b1[7]}}, inst.b1};
		else
			next_pc = pc + {14'd0, f8_pkg::inst_size(inst.opcode)};
		if (reset)
			rd_addr = `F8_RESET_PC;
		else if (more && inst.opcode == f8_pkg::OP_POPW_Y)
			rd_addr = regs.sp;
		else if (more)
			rd_addr = pc + 16'd2;
		else
			rd_addr = next_pc;
	end

	// odd address puts the second byte in the next even word
	assign rd_index = rd_addr[`F8_ADDR_W-1:1];
	assign rd_addr_odd = rd_index;
	assign rd_addr_even = rd_addr[0] ? rd_index + 1'b1 : rd_index;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= `F8_RESET_PC;
			upper <= 1'b0;
			operand <= 1'b0;
		end
		else
		begin
			pc <= next_pc;
			upper <= more && f8_pkg::is_three_byte(inst.opcode);
			operand <= more && inst.opcode == f8_pkg::OP_POPW_Y;
		end
	end

	always_ff @(posedge clk)
	begin
		if (first)
			inst_q <= inst;
	end
endmodule

// ==== f8_pkg.sv ====
`include "f8_cfg.svh"

package f8_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] word_t;
	typedef logic [`F8_BANK_W-1:0] bank_addr_t;

	typedef enum logic [7:0]
	{
		OP_NOP = 8'h00,
		OP_TRAP = 8'h01,
		OP_LD_XL_IMMD = 8'h10,
		OP_ADD_XL_IMMD = 8'h11,
		OP_SUB_XL_IMMD = 8'h12,
		OP_ADC_XL_IMMD = 8'h13,
		OP_SBC_XL_IMMD = 8'h14,
		OP_AND_XL_IMMD = 8'h15,
		OP_OR_XL_IMMD = 8'h16,
		OP_XOR_XL_IMMD = 8'h17,
		OP_INC_XL = 8'h18,
		OP_DEC_XL = 8'h19,
		OP_LDW_Y_IMMD = 8'h20,
		OP_ADDW_Y_IMMD = 8'h21,
		OP_SUBW_Y_IMMD = 8'h22,
		OP_INCW_Y = 8'h23,
		OP_LD_DIR_XL = 8'h30,
		OP_LDW_DIR_Y = 8'h31,
		OP_LDW_SP_Y = 8'h40,
		OP_PUSHW_Y = 8'h41,
		OP_POPW_Y = 8'h42,
		OP_JR_D = 8'h50,
		OP_JRZ_D = 8'h51,
		OP_JRNZ_D = 8'h52,
		OP_JRC_D = 8'h53
	} opcode_t;

	typedef struct packed
	{
		logic o;
		logic z;
		logic n;
		logic c;
		logic h;
	} flags_t;

	typedef struct packed
	{
		word_t x;
		word_t y;
		word_t sp;
		flags_t f;
	} regs_t;

	// b1 follows the opcode, b2 follows b1
	typedef struct packed
	{
		opcode_t opcode;
		byte_t b1;
		byte_t b2;
	} inst_t;

	typedef struct packed
	{
		byte_t result;
		flags_t f;
	} alu8_res_t;

	typedef struct packed
	{
		word_t result;
		flags_t f;
	} alu16_res_t;

	typedef struct packed
	{
		bank_addr_t addr;
		byte_t data;
		logic en;
	} bank_wr_t;

	function automatic logic [1:0] inst_size(opcode_t opcode);
		case (opcode)
			OP_LDW_Y_IMMD, OP_ADDW_Y_IMMD, OP_SUBW_Y_IMMD, OP_LD_DIR_XL, OP_LDW_DIR_Y:
				return 2'd3;
			OP_LD_XL_IMMD, OP_ADD_XL_IMMD, OP_SUB_XL_IMMD, OP_ADC_XL_IMMD,
			OP_SBC_XL_IMMD, OP_AND_XL_IMMD, OP_OR_XL_IMMD, OP_XOR_XL_IMMD,
			OP_JR_D, OP_JRZ_D, OP_JRNZ_D, OP_JRC_D:
				return 2'd2;
			default:
				return 2'd1;
		endcase
	endfunction

	function automatic logic is_three_byte(opcode_t opcode);
		return inst_size(opcode) == 2'd3;
	endfunction

endpackage

// ==== f8_tb_tests.svh ====
`ifndef F8_TB_TESTS_SVH
`define F8_TB_TESTS_SVH

f8_pkg::byte_t prog [$];

function automatic f8_pkg::byte_t fill_byte(f8_pkg::word_t addr);
	return addr[15:8] ^ addr[7:0] ^ 8'h6b;
endfunction

function automatic f8_pkg::byte_t read_byte(f8_pkg::word_t addr);
	if (addr[0])
		return bank_odd[addr[15:1]];
	else
		return bank_even[addr[15:1]];
endfunction

// byte op on XL, carry in the top bit of the result
function automatic logic [8:0] alu8_model(f8_pkg::opcode_t op, f8_pkg::byte_t x,
	f8_pkg::byte_t b, logic c);
	int sum;
	sum = int'(x);
	case (op)
		f8_pkg::OP_ADD_XL_IMMD:
			sum = int'(x) + int'(b);
		f8_pkg::OP_ADC_XL_IMMD:
			sum = int'(x) + int'(b) + int'(c);
		f8_pkg::OP_SUB_XL_IMMD:
			sum = int'(x) + (255 - int'(b)) + 1;
		f8_pkg::OP_SBC_XL_IMMD:
			sum = int'(x) + (255 - int'(b)) + int'(c);
		f8_pkg::OP_INC_XL:
			sum = int'(x) + 1;
		f8_pkg::OP_DEC_XL:
			sum = int'(x) + 254 + 1;
		f8_pkg::OP_AND_XL_IMMD:
			return {c, x & b};
		f8_pkg::OP_OR_XL_IMMD:
			return {c, x | b};
		f8_pkg::OP_XOR_XL_IMMD:
			return {c, x ^ b};
		default:
			return {c, x};
	endcase
	return {sum[8], sum[7:0]};
endfunction

function automatic f8_pkg::word_t alu16_model(f8_pkg::opcode_t op, f8_pkg::word_t y,
	f8_pkg::word_t imm);
	if (op == f8_pkg::OP_ADDW_Y_IMMD)
		return y + imm;
	else if (op == f8_pkg::OP_SUBW_Y_IMMD)
		return y - imm;
	else
		return y + 16'd1;
endfunction

task automatic fill_memory();
	for (int i = 0; i < bank_words; i++)
	begin
		bank_even[i] = fill_byte({i[14:0], 1'b0});
		bank_odd[i] = fill_byte({i[14:0], 1'b1});
	end
endtask

task automatic emit_op(f8_pkg::opcode_t op);
	prog.push_back(op);
endtask

task automatic emit_op8(f8_pkg::opcode_t op, f8_pkg::byte_t b1);
	prog.push_back(op);
	prog.push_back(b1);
endtask

// immediate and address go low byte first
task automatic emit_op16(f8_pkg::opcode_t op, f8_pkg::word_t w);
	prog.push_back(op);
	prog.push_back(w[7:0]);
	prog.push_back(w[15:8]);
endtask

task automatic store_marker(f8_pkg::byte_t value, f8_pkg::word_t addr);
	emit_op8(f8_pkg::OP_LD_XL_IMMD, value);
	emit_op16(f8_pkg::OP_LD_DIR_XL, addr);
endtask

task automatic load_program();
	f8_pkg::word_t addr;
	for (int i = 0; i < prog.size(); i++)
	begin
		addr = `F8_RESET_PC + 16'(i);
		if (addr[0])
			bank_odd[addr[15:1]] = prog[i];
		else
			bank_even[addr[15:1]] = prog[i];
	end
	prog.delete();
endtask

task automatic run_program();
	@(negedge clk);
	reset = 1'b1;
	load_program();
	log_addr.delete();
	log_data.delete();
	repeat (3)
	begin
		@(posedge clk);
		assert (!wr_even.en && !wr_odd.en && !trap)
		else
		begin
			$display("a write enable or trap was high while reset was high");
			test_errors++;
		end
	end
	@(negedge clk);
	reset = 1'b0;
	do
		@(posedge clk);
	while (trap !== 1'b1);
	repeat (3)
	begin
		@(posedge clk);
		assert (trap === 1'b1)
		else
		begin
			$display("trap dropped while the core was halted");
			test_errors++;
		end
	end
endtask

task automatic check_equal(string name, f8_pkg::word_t expected, f8_pkg::word_t actual);
	assert (actual === expected)
	else
	begin
		$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		test_errors++;
	end
endtask

// last logged write to addr
task automatic check_write(string name, f8_pkg::word_t addr, f8_pkg::byte_t expected);
	int hit;
	hit = -1;
	foreach (log_addr[i])
		if (log_addr[i] == addr)
			hit = i;
	assert (hit >= 0)
	else
	begin
		$display("%s: no write to address %h was seen", name, addr);
		test_errors++;
	end
	if (hit >= 0)
		check_equal(name, {8'h00, expected}, {8'h00, log_data[hit]});
endtask

task automatic check_word_store(string name, f8_pkg::word_t addr, f8_pkg::word_t value);
	check_write({name, " low"}, addr, value[7:0]);
	check_write({name, " high"}, addr + 16'd1, value[15:8]);
	check_equal({name, " banks"}, value, {read_byte(addr + 16'd1), read_byte(addr)});
endtask

task automatic check_write_count(string name, int expected);
	check_equal({name, " write count"}, 16'(expected), 16'(log_addr.size()));
endtask

task automatic finish_test(string name);
	if (test_errors == 0)
	begin
		pass_count++;
		$display("%s: ok", name);
	end
	else
	begin
		fail_count++;
		$display("%s: %0d errors", name, test_errors);
	end
endtask

task automatic reset_store_test();
	f8_pkg::byte_t value;
	f8_pkg::word_t addr;
	test_errors = 0;
	value = 8'($random(seed));
	addr = 16'h0100 + 16'($random(seed) & 255);
	emit_op8(f8_pkg::OP_LD_XL_IMMD, value);
	emit_op16(f8_pkg::OP_LD_DIR_XL, addr);
	emit_op(f8_pkg::OP_TRAP);
	run_program();
	check_write_count("reset_store", 1);
	check_write("reset_store", addr, value);
	finish_test("reset_store");
endtask

task automatic byte_alu_test();
	f8_pkg::opcode_t ops [9];
	f8_pkg::opcode_t op;
	f8_pkg::byte_t x;
	f8_pkg::byte_t b;
	logic c;
	logic [8:0] r;
	f8_pkg::word_t addr;
	test_errors = 0;
	ops = '{f8_pkg::OP_ADD_XL_IMMD, f8_pkg::OP_SUB_XL_IMMD, f8_pkg::OP_ADC_XL_IMMD,
		f8_pkg::OP_SBC_XL_IMMD, f8_pkg::OP_AND_XL_IMMD, f8_pkg::OP_OR_XL_IMMD,
		f8_pkg::OP_XOR_XL_IMMD, f8_pkg::OP_INC_XL, f8_pkg::OP_DEC_XL};
	for (int n = 0; n < 20; n++)
	begin
		x = 8'($random(seed));
		c = 1'b0;
		emit_op8(f8_pkg::OP_LD_XL_IMMD, x);
		// two ops so that ADC and SBC see the carry of the first
		repeat (2)
		begin
			op = ops[$unsigned($random(seed)) % 9];
			b = 8'($random(seed));
			if (op == f8_pkg::OP_INC_XL || op == f8_pkg::OP_DEC_XL)
				emit_op(op);
			else
				emit_op8(op, b);
			r = alu8_model(op, x, b, c);
			c = r[8];
			x = r[7:0];
		end
		addr = 16'h0100 + 16'(n);
		emit_op16(f8_pkg::OP_LD_DIR_XL, addr);
		emit_op(f8_pkg::OP_TRAP);
		run_program();
		check_write_count($sformatf("byte_alu chain %0d", n), 1);
		check_write($sformatf("byte_alu chain %0d", n), addr, x);
	end
	finish_test("byte_alu");
endtask

task automatic word_alu_test();
	f8_pkg::opcode_t ops [3];
	f8_pkg::opcode_t op;
	f8_pkg::word_t y;
	f8_pkg::word_t imm;
	f8_pkg::word_t stored [2];
	f8_pkg::word_t addrs [2];
	test_errors = 0;
	ops = '{f8_pkg::OP_ADDW_Y_IMMD, f8_pkg::OP_SUBW_Y_IMMD, f8_pkg::OP_INCW_Y};
	for (int n = 0; n < 6; n++)
	begin
		y = 16'($random(seed));
		emit_op16(f8_pkg::OP_LDW_Y_IMMD, y);
		// first store aligned, second at an odd address
		for (int k = 0; k < 2; k++)
		begin
			op = ops[$unsigned($random(seed)) % 3];
			imm = 16'($random(seed));
			if (op == f8_pkg::OP_INCW_Y)
				emit_op(op);
			else
				emit_op16(op, imm);
			y = alu16_model(op, y, imm);
			stored[k] = y;
			addrs[k] = 16'h0200 + 16'(8 * n) + 16'(3 * k);
			emit_op16(f8_pkg::OP_LDW_DIR_Y, addrs[k]);
		end
		emit_op(f8_pkg::OP_TRAP);
		run_program();
		check_write_count($sformatf("word_alu seq %0d", n), 4);
		for (int k = 0; k < 2; k++)
			check_word_store($sformatf("word_alu seq %0d store %0d", n, k), addrs[k], stored[k]);
	end
	finish_test("word_alu");
endtask

task automatic stack_test();
	f8_pkg::word_t s;
	f8_pkg::word_t v;
	test_errors = 0;
	s = 16'h1000 + 16'($random(seed) & 16'h0fff);
	v = 16'($random(seed));
	emit_op16(f8_pkg::OP_LDW_Y_IMMD, s);
	emit_op(f8_pkg::OP_LDW_SP_Y);
	emit_op16(f8_pkg::OP_LDW_Y_IMMD, v);
	emit_op(f8_pkg::OP_PUSHW_Y);
	emit_op16(f8_pkg::OP_LDW_Y_IMMD, 16'h0000);
	emit_op(f8_pkg::OP_POPW_Y);
	emit_op16(f8_pkg::OP_LDW_DIR_Y, 16'h0301);
	emit_op(f8_pkg::OP_TRAP);
	run_program();
	check_write_count("stack", 4);
	check_word_store("stack push", s - 16'd2, v);
	check_word_store("stack pop", 16'h0301, v);
	finish_test("stack");
endtask

task automatic branch_test();
	int n;
	f8_pkg::word_t y;
	test_errors = 0;
	n = 1 + int'($unsigned($random(seed)) % 8);
	y = 16'h0000;
	repeat (n)
		y = alu16_model(f8_pkg::OP_ADDW_Y_IMMD, y, 16'h0103);
	emit_op16(f8_pkg::OP_LDW_Y_IMMD, 16'h0000);
	emit_op8(f8_pkg::OP_LD_XL_IMMD, 8'(n));
	emit_op16(f8_pkg::OP_ADDW_Y_IMMD, 16'h0103);
	emit_op(f8_pkg::OP_DEC_XL);
	emit_op8(f8_pkg::OP_JRNZ_D, 8'hfc);
	emit_op16(f8_pkg::OP_LDW_DIR_Y, 16'h0400);
	// z still set by the last DEC, skip the first marker
	emit_op8(f8_pkg::OP_JRZ_D, 8'h07);
	store_marker(8'hbb, 16'h0410);
	store_marker(8'h5a, 16'h0410);
	emit_op8(f8_pkg::OP_LD_XL_IMMD, 8'hf0);
	emit_op8(f8_pkg::OP_ADD_XL_IMMD, 8'h20);
	emit_op8(f8_pkg::OP_JRC_D, 8'h07);
	store_marker(8'hcc, 16'h0411);
	store_marker(8'ha5, 16'h0411);
	// z clear here, c clears with the next ADD
	emit_op8(f8_pkg::OP_JRZ_D, 8'h07);
	store_marker(8'h3c, 16'h0412);
	emit_op8(f8_pkg::OP_ADD_XL_IMMD, 8'h01);
	emit_op8(f8_pkg::OP_JRC_D, 8'h07);
	store_marker(8'hc3, 16'h0413);
	emit_op(f8_pkg::OP_TRAP);
	run_program();
	check_write_count("branch", 6);
	check_word_store("branch loop sum", 16'h0400, y);
	check_write("branch jrz taken", 16'h0410, 8'h5a);
	check_write("branch jrc taken", 16'h0411, 8'ha5);
	check_write("branch jrz not taken", 16'h0412, 8'h3c);
	check_write("branch jrc not taken", 16'h0413, 8'hc3);
	finish_test("branch");
endtask

`endif

// ==== f8_tb.sv ====
`timescale 1ns/1ns

`include "f8_cfg.svh"

module f8_tb;
	localparam int bank_words = 1 << `F8_BANK_W;
	// five tests of up to 200 cycles each, with margin
	localparam int max_cycles = 2000;

	logic clk;
	logic reset;
	f8_pkg::byte_t rd_data_even = 8'h00;
	f8_pkg::byte_t rd_data_odd = 8'h00;
	f8_pkg::bank_addr_t rd_addr_even;
	f8_pkg::bank_addr_t rd_addr_odd;
	f8_pkg::bank_wr_t wr_even;
	f8_pkg::bank_wr_t wr_odd;
	logic trap;

	f8_pkg::byte_t bank_even [0:bank_words-1];
	f8_pkg::byte_t bank_odd [0:bank_words-1];
	f8_pkg::bank_addr_t rd_index_even;
	f8_pkg::bank_addr_t rd_index_odd;
	f8_pkg::word_t log_addr [$];
	f8_pkg::byte_t log_data [$];
	integer seed = 5071;
	int cycle_count = 0;
	int test_errors = 0;
	int pass_count = 0;
	int fail_count = 0;

	f8_cpu dut_i
	(
		.clk(clk),
		.reset(reset),
		.rd_data_even(rd_data_even),
		.rd_data_odd(rd_data_odd),
		.rd_addr_even(rd_addr_even),
		.rd_addr_odd(rd_addr_odd),
		.wr_even(wr_even),
		.wr_odd(wr_odd),
		.trap(trap)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// address latched at the rising edge, writes commit there too
	always @(posedge clk)
	begin
		rd_index_even <= rd_addr_even;
		rd_index_odd <= rd_addr_odd;
		if (wr_even.en)
		begin
			bank_even[wr_even.addr] = wr_even.data;
			log_addr.push_back({wr_even.addr, 1'b0});
			log_data.push_back(wr_even.data);
		end
		if (wr_odd.en)
		begin
			bank_odd[wr_odd.addr] = wr_odd.data;
			log_addr.push_back({wr_odd.addr, 1'b1});
			log_data.push_back(wr_odd.data);
		end
	end

	// read data for the latched address, driven on the falling edge
	always @(negedge clk)
	begin
		rd_data_even <= bank_even[rd_index_even];
		rd_data_odd <= bank_odd[rd_index_odd];
	end

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= max_cycles)
		begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	`include "f8_tb_tests.svh"

	initial
	begin
		reset = 1'b1;
		fill_memory();
		reset_store_test();
		byte_alu_test();
		word_alu_test();
		stack_test();
		branch_test();
		$display("tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end
endmodule

// ==== src.f ====
+incdir+.
f8_pkg.sv
f8_addsub.sv
f8_alu8.sv
f8_alu16.sv
f8_fetch.sv
f8_execute.sv
f8_cpu.sv
f8_tb.sv
